// File: source/apu_pkg.sv
package apu_pkg;

    typedef logic [5:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [3:0]  amp_t;     // channel level before the mixer
    typedef logic [10:0] freq_t;
    typedef logic [23:0] sample_t;

    typedef enum logic [1:0] {
        MON_SQUARE,
        MON_WAVE,
        MON_MIX,
        MON_RAMP
    } mon_sel_t;

    typedef enum logic {
        ENV_DOWN,
        ENV_UP
    } env_dir_t;

    // low six bits of the console's 0xff10..0xff3f map
    localparam reg_addr_t ADDR_NR10      = 6'h10;
    localparam reg_addr_t ADDR_NR11      = 6'h11;
    localparam reg_addr_t ADDR_NR12      = 6'h12;
    localparam reg_addr_t ADDR_NR13      = 6'h13;
    localparam reg_addr_t ADDR_NR14      = 6'h14;
    localparam reg_addr_t ADDR_NR30      = 6'h1a;
    localparam reg_addr_t ADDR_NR31      = 6'h1b;
    localparam reg_addr_t ADDR_NR32      = 6'h1c;
    localparam reg_addr_t ADDR_NR33      = 6'h1d;
    localparam reg_addr_t ADDR_NR34      = 6'h1e;
    localparam reg_addr_t ADDR_NR50      = 6'h24;
    localparam reg_addr_t ADDR_NR51      = 6'h25;
    localparam reg_addr_t ADDR_NR52      = 6'h26;
    localparam reg_addr_t ADDR_MON       = 6'h27; // free slot, not on the console
    localparam reg_addr_t ADDR_WAVE_BASE = 6'h30; // sixteen bytes up to 0x3f

    localparam int FRAME_DIV   = 195312;          // 100 MHz / 512 Hz
    localparam int FRAME_CNT_W = $clog2(FRAME_DIV);
    localparam int TIMER_DIV   = 24;              // roughly the console clock
    localparam int TIMER_CNT_W = $clog2(TIMER_DIV);

    // one byte per duty code, bit n is duty step n
    localparam logic [31:0] DUTY_TABLE = {
        8'b0111_1110,   // 75 %
        8'b1000_0111,   // 50 %
        8'b1000_0001,   // 25 %
        8'b0000_0001    // 12.5 %
    };

endpackage

// File: source/chan_regs_if.sv
`timescale 1ns/1ps

interface chan_regs_if;
    apu_pkg::reg_data_t nrx0;
    apu_pkg::reg_data_t nrx1;
    apu_pkg::reg_data_t nrx2;
    apu_pkg::reg_data_t nrx3;
    apu_pkg::reg_data_t nrx4;
    logic               trigger;    // one cycle, with nrx4 already updated

    modport ctrl (
        output nrx0, nrx1, nrx2, nrx3, nrx4,
        output trigger
    );

    modport chan (
        input nrx0, nrx1, nrx2, nrx3, nrx4,
        input trigger
    );
endinterface

// File: source/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic clk_100,
    input  logic arst_n,
    input  logic power_on,
    output logic length_tick,
    output logic env_tick
);
    logic [apu_pkg::FRAME_CNT_W-1:0] div_cnt;
    logic [2:0]                      step;
    logic                            step_end;

    assign step_end = (div_cnt == (apu_pkg::FRAME_CNT_W)'(apu_pkg::FRAME_DIV - 1));

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt     <= '0;
            step        <= '0;
            length_tick <= 1'b0;
            env_tick    <= 1'b0;
        end else if (!power_on) begin
            // sequencer sits at step 0 while the unit is off
            div_cnt     <= '0;
            step        <= '0;
            length_tick <= 1'b0;
            env_tick    <= 1'b0;
        end else begin
            length_tick <= 1'b0;
            env_tick    <= 1'b0;
            if (step_end) begin
                div_cnt     <= '0;
                step        <= step + 3'd1;
                length_tick <= ~step[0];        // steps 0 2 4 6, 256 Hz
                env_tick    <= (step == 3'd7);  // 64 Hz
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end
endmodule

// File: source/apu_regs.sv
`timescale 1ns/1ps

module apu_regs (
    input  logic               clk_100,
    input  logic               arst_n,
    input  logic               reg_wr,
    input  apu_pkg::reg_addr_t reg_addr,
    input  apu_pkg::reg_data_t reg_wdata,
    output apu_pkg::reg_data_t reg_rdata,
    chan_regs_if.ctrl          sq_regs,
    chan_regs_if.ctrl          wv_regs,
    input  logic               sq_active,
    input  logic               wv_active,
    input  logic [4:0]         wave_pos,
    output apu_pkg::amp_t      wave_sample,
    output logic               power_on,
    output apu_pkg::reg_data_t nr50,
    output apu_pkg::reg_data_t nr51,
    output apu_pkg::mon_sel_t  mon_sel
);
    apu_pkg::reg_data_t nr10, nr11, nr12, nr13, nr14;
    apu_pkg::reg_data_t nr30, nr31, nr32, nr33, nr34;
    apu_pkg::reg_data_t wave_ram [16];
    apu_pkg::reg_data_t wave_byte;
    logic               wave_hit;

    assign wave_hit = (reg_addr[5:4] == apu_pkg::ADDR_WAVE_BASE[5:4]);

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            {nr10, nr11, nr12, nr13, nr14, nr30, nr31, nr32, nr33, nr34, nr50, nr51} <= '0;
            sq_regs.trigger <= 1'b0;
            wv_regs.trigger <= 1'b0;
            power_on        <= 1'b0;
            mon_sel         <= apu_pkg::MON_MIX;
        end else begin
            sq_regs.trigger <= 1'b0;
            wv_regs.trigger <= 1'b0;
            if (!power_on) begin
                // unit off, control bytes held clear
                {nr10, nr11, nr12, nr13, nr14, nr30, nr31, nr32, nr33, nr34, nr50, nr51} <= '0;
            end else if (reg_wr) begin
                case (reg_addr)
                    apu_pkg::ADDR_NR10: nr10 <= reg_wdata;
                    apu_pkg::ADDR_NR11: nr11 <= reg_wdata;
                    apu_pkg::ADDR_NR12: nr12 <= reg_wdata;
                    apu_pkg::ADDR_NR13: nr13 <= reg_wdata;
                    apu_pkg::ADDR_NR14: begin
                        nr14            <= reg_wdata;
                        sq_regs.trigger <= reg_wdata[7];
                    end
                    apu_pkg::ADDR_NR30: nr30 <= reg_wdata;
                    apu_pkg::ADDR_NR31: nr31 <= reg_wdata;
                    apu_pkg::ADDR_NR32: nr32 <= reg_wdata;
                    apu_pkg::ADDR_NR33: nr33 <= reg_wdata;
                    apu_pkg::ADDR_NR34: begin
                        nr34            <= reg_wdata;
                        wv_regs.trigger <= reg_wdata[7];
                    end
                    apu_pkg::ADDR_NR50: nr50 <= reg_wdata;
                    apu_pkg::ADDR_NR51: nr51 <= reg_wdata;
                    default: ;
                endcase
            end
            // power bit and monitor select stay writable when off
            if (reg_wr && reg_addr == apu_pkg::ADDR_NR52) power_on <= reg_wdata[7];
            if (reg_wr && reg_addr == apu_pkg::ADDR_MON) begin
                mon_sel <= apu_pkg::mon_sel_t'(reg_wdata[1:0]);
            end
        end
    end

    always_ff @(posedge clk_100) begin
        if (reg_wr && wave_hit) wave_ram[reg_addr[3:0]] <= reg_wdata;
    end

    // high nibble plays first
    assign wave_byte   = wave_ram[wave_pos[4:1]];
    assign wave_sample = wave_pos[0] ? wave_byte[3:0] : wave_byte[7:4];

    assign sq_regs.nrx0 = nr10;
    assign sq_regs.nrx1 = nr11;
    assign sq_regs.nrx2 = nr12;
    assign sq_regs.nrx3 = nr13;
    assign sq_regs.nrx4 = nr14;
    assign wv_regs.nrx0 = nr30;
    assign wv_regs.nrx1 = nr31;
    assign wv_regs.nrx2 = nr32;
    assign wv_regs.nrx3 = nr33;
    assign wv_regs.nrx4 = nr34;

    always_comb begin
        reg_rdata = '0;
        if (wave_hit) begin
            reg_rdata = wave_ram[reg_addr[3:0]];
        end else begin
            case (reg_addr)
                apu_pkg::ADDR_NR10: reg_rdata = nr10;
                apu_pkg::ADDR_NR11: reg_rdata = nr11;
                apu_pkg::ADDR_NR12: reg_rdata = nr12;
                apu_pkg::ADDR_NR13: reg_rdata = nr13;
                apu_pkg::ADDR_NR14: reg_rdata = nr14;
                apu_pkg::ADDR_NR30: reg_rdata = nr30;
                apu_pkg::ADDR_NR31: reg_rdata = nr31;
                apu_pkg::ADDR_NR32: reg_rdata = nr32;
                apu_pkg::ADDR_NR33: reg_rdata = nr33;
                apu_pkg::ADDR_NR34: reg_rdata = nr34;
                apu_pkg::ADDR_NR50: reg_rdata = nr50;
                apu_pkg::ADDR_NR51: reg_rdata = nr51;
                apu_pkg::ADDR_NR52: reg_rdata = {power_on, 5'd0, wv_active, sq_active};
                apu_pkg::ADDR_MON:  reg_rdata = {6'd0, mon_sel};
                default: ;
            endcase
        end
    end
endmodule

// File: source/square_channel.sv
`timescale 1ns/1ps

module square_channel (
    input  logic          clk_100,
    input  logic          arst_n,
    chan_regs_if.chan     regs,
    input  logic          power_on,
    input  logic          length_tick,
    input  logic          env_tick,
    output apu_pkg::amp_t amp,
    output logic          active
);
    apu_pkg::freq_t                  freq;
    apu_pkg::freq_t                  period_cnt;
    logic [apu_pkg::TIMER_CNT_W-1:0] prescale;
    logic                            timer_tick;
    logic [2:0]                      duty_step;
    logic                            duty_bit;
    logic [6:0]                      length_cnt;
    apu_pkg::amp_t                   volume;
    logic [2:0]                      env_cnt;
    apu_pkg::env_dir_t               env_dir;

    assign freq       = {regs.nrx4[2:0], regs.nrx3};
    assign env_dir    = apu_pkg::env_dir_t'(regs.nrx2[3]);
    assign timer_tick = (prescale == (apu_pkg::TIMER_CNT_W)'(apu_pkg::TIMER_DIV - 1));
    assign duty_bit   = apu_pkg::DUTY_TABLE[{regs.nrx1[7:6], duty_step}];

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) prescale <= '0;
        else if (timer_tick) prescale <= '0;
        else prescale <= prescale + 1'b1;
    end

    // count up from freq to 0x7ff, so 2048 - freq ticks per duty step
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
            duty_step  <= '0;
        end else if (regs.trigger) begin
            period_cnt <= freq;
            duty_step  <= '0;
        end else if (timer_tick) begin
            if (period_cnt == '1) begin
                period_cnt <= freq;
                duty_step  <= duty_step + 3'd1;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    // volume envelope, period 0 holds the level
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            volume  <= '0;
            env_cnt <= '0;
        end else if (regs.trigger) begin
            volume  <= regs.nrx2[7:4];
            env_cnt <= '0;
        end else if (env_tick && regs.nrx2[2:0] != 3'd0) begin
            if (env_cnt == regs.nrx2[2:0] - 3'd1) begin
                env_cnt <= '0;
                if (env_dir == apu_pkg::ENV_UP && volume != 4'hf) begin
                    volume <= volume + 4'd1;
                end else if (env_dir == apu_pkg::ENV_DOWN && volume != 4'h0) begin
                    volume <= volume - 4'd1;
                end
            end else begin
                env_cnt <= env_cnt + 3'd1;
            end
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            length_cnt <= '0;
            active     <= 1'b0;
        end else if (!power_on) begin
            length_cnt <= '0;
            active     <= 1'b0;
        end else if (regs.trigger) begin
            active <= 1'b1;
            if (length_cnt == '0) length_cnt <= 7'd64 - {1'b0, regs.nrx1[5:0]};
        end else if (length_tick && regs.nrx4[6] && length_cnt != '0) begin
            length_cnt <= length_cnt - 7'd1;
            if (length_cnt == 7'd1) active <= 1'b0;  // last tick ends the note
        end
    end

    assign amp = (active && power_on && duty_bit) ? volume : '0;
endmodule

// File: source/wave_channel.sv
`timescale 1ns/1ps

module wave_channel (
    input  logic          clk_100,
    input  logic          arst_n,
    chan_regs_if.chan     regs,
    input  logic          power_on,
    input  logic          length_tick,
    output logic [4:0]    wave_pos,
    input  apu_pkg::amp_t wave_sample,
    output apu_pkg::amp_t amp,
    output logic          active
);
    apu_pkg::freq_t                  freq;
    apu_pkg::freq_t                  period_cnt;
    logic [apu_pkg::TIMER_CNT_W-1:0] prescale;
    logic                            timer_tick;
    logic [8:0]                      length_cnt;
    apu_pkg::amp_t                   shifted;

    assign freq       = {regs.nrx4[2:0], regs.nrx3};
    assign timer_tick = (prescale == (apu_pkg::TIMER_CNT_W)'(apu_pkg::TIMER_DIV - 1));

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) prescale <= '0;
        else if (timer_tick) prescale <= '0;
        else prescale <= prescale + 1'b1;
    end

    // one nibble per timer expiry
    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            period_cnt <= '0;
            wave_pos   <= '0;
        end else if (regs.trigger) begin
            period_cnt <= freq;
            wave_pos   <= '0;
        end else if (timer_tick) begin
            if (period_cnt == '1) begin
                period_cnt <= freq;
                wave_pos   <= wave_pos + 5'd1;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            length_cnt <= '0;
            active     <= 1'b0;
        end else if (!power_on) begin
            length_cnt <= '0;
            active     <= 1'b0;
        end else if (!regs.nrx0[7]) begin
            active <= 1'b0;                     // DAC off
        end else if (regs.trigger) begin
            active <= 1'b1;
            if (length_cnt == '0) length_cnt <= 9'd256 - {1'b0, regs.nrx1};
        end else if (length_tick && regs.nrx4[6] && length_cnt != '0) begin
            length_cnt <= length_cnt - 9'd1;
            if (length_cnt == 9'd1) active <= 1'b0;
        end
    end

    always_comb begin
        case (regs.nrx2[6:5])
            2'd0: shifted = '0;                 // mute
            2'd1: shifted = wave_sample;
            2'd2: shifted = wave_sample >> 1;
            default: shifted = wave_sample >> 2;
        endcase
    end

    assign amp = (active && power_on) ? shifted : '0;
endmodule

// File: source/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer (
    input  logic               clk_100,
    input  logic               arst_n,
    input  logic               new_sample,
    input  logic               power_on,
    input  apu_pkg::reg_data_t nr50,
    input  apu_pkg::reg_data_t nr51,
    input  apu_pkg::mon_sel_t  mon_sel,
    input  apu_pkg::amp_t      sq_amp,
    input  apu_pkg::amp_t      wv_amp,
    output apu_pkg::sample_t   sample_left,
    output apu_pkg::sample_t   sample_right,
    output logic               sample_valid
);
    apu_pkg::sample_t next_left, next_right;
    logic [5:0]       ramp;

    // pan and scale one side, at most 30 * 8
    function automatic logic [7:0] side_mix(input logic sq_en, input logic wv_en,
                                            input logic [2:0] vol,
                                            input apu_pkg::amp_t sq,
                                            input apu_pkg::amp_t wv);
        logic [4:0] sum;
        sum = (sq_en ? {1'b0, sq} : 5'd0) + (wv_en ? {1'b0, wv} : 5'd0);
        return {3'd0, sum} * ({5'd0, vol} + 8'd1);
    endfunction

    always_comb begin
        next_left  = '0;
        next_right = '0;
        case (mon_sel)
            apu_pkg::MON_SQUARE: next_left = {sq_amp, 20'd0};
            apu_pkg::MON_WAVE:   next_left = {wv_amp, 20'd0};
            apu_pkg::MON_MIX: begin
                next_left  = {3'd0, side_mix(nr51[4], nr51[5], nr50[6:4], sq_amp, wv_amp), 13'd0};
                next_right = {3'd0, side_mix(nr51[0], nr51[1], nr50[2:0], sq_amp, wv_amp), 13'd0};
            end
            apu_pkg::MON_RAMP:   next_left = {ramp, 18'd0};
            default: ;
        endcase
        if (mon_sel != apu_pkg::MON_MIX) next_right = next_left;   // mono sources
        if (!power_on && mon_sel != apu_pkg::MON_RAMP) begin
            next_left  = '0;
            next_right = '0;
        end
    end

    always_ff @(posedge clk_100 or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
            ramp         <= '0;
        end else begin
            sample_valid <= new_sample;
            if (new_sample) ramp <= ramp + 6'd1;  // wraps at 64
        end
    end

    always_ff @(posedge clk_100) begin
        if (new_sample) begin
            sample_left  <= next_left;
            sample_right <= next_right;
        end
    end
endmodule

// File: source/apu_top.sv
`timescale 1ns/1ps

module apu_top (
    input  logic               clk_100,
    input  logic               arst_n,
    input  logic               reg_wr,
    input  apu_pkg::reg_addr_t reg_addr,
    input  apu_pkg::reg_data_t reg_wdata,
    output apu_pkg::reg_data_t reg_rdata,
    input  logic               new_sample,
    output apu_pkg::sample_t   sample_left,
    output apu_pkg::sample_t   sample_right,
    output logic               sample_valid
);
    chan_regs_if sq_regs ();
    chan_regs_if wv_regs ();

    logic               power_on;
    logic               length_tick, env_tick;
    logic               sq_active, wv_active;
    apu_pkg::amp_t      sq_amp, wv_amp;
    logic [4:0]         wave_pos;
    apu_pkg::amp_t      wave_sample;
    apu_pkg::reg_data_t nr50, nr51;
    apu_pkg::mon_sel_t  mon_sel;

    apu_regs u_regs (
        .clk_100, .arst_n,
        .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
        .sq_regs     (sq_regs.ctrl),
        .wv_regs     (wv_regs.ctrl),
        .sq_active, .wv_active,
        .wave_pos, .wave_sample,
        .power_on, .nr50, .nr51, .mon_sel
    );

    frame_sequencer u_frame_seq (
        .clk_100, .arst_n, .power_on,
        .length_tick, .env_tick
    );

    square_channel u_square (
        .clk_100, .arst_n,
        .regs        (sq_regs.chan),
        .power_on, .length_tick, .env_tick,
        .amp         (sq_amp),
        .active      (sq_active)
    );

    wave_channel u_wave (
        .clk_100, .arst_n,
        .regs        (wv_regs.chan),
        .power_on, .length_tick,
        .wave_pos, .wave_sample,
        .amp         (wv_amp),
        .active      (wv_active)
    );

    sound_mixer u_mixer (
        .clk_100, .arst_n, .new_sample, .power_on,
        .nr50, .nr51, .mon_sel,
        .sq_amp, .wv_amp,
        .sample_left, .sample_right, .sample_valid
    );
endmodule

// File: verification/tb_apu_top.sv
`timescale 1ns/1ps

module tb_apu_top;
    localparam int SAMPLE_GAP   = 200;            // cycles between new_sample strobes
    localparam int SAMPLE_WAIT  = 4 * SAMPLE_GAP;
    localparam int DUTY_SAMPLES = 504;            // three full beat periods at freq 0x7f9
    localparam int LENGTH_WAIT  = 1_000_000;

    logic               clk_100;
    logic               arst_n;
    logic               reg_wr;
    apu_pkg::reg_addr_t reg_addr;
    apu_pkg::reg_data_t reg_wdata;
    apu_pkg::reg_data_t reg_rdata;
    logic               new_sample;
    apu_pkg::sample_t   sample_left;
    apu_pkg::sample_t   sample_right;
    logic               sample_valid;
    logic               new_sample_q;             // strobe as seen one edge earlier

    int                 error_count;
    int                 timeout_count;
    integer             seed;
    apu_pkg::sample_t   left_q [$];
    apu_pkg::sample_t   right_q [$];
    apu_pkg::reg_data_t wave_image [16];          // what the wave RAM should hold

    apu_top dut (
        .clk_100, .arst_n,
        .reg_wr, .reg_addr, .reg_wdata, .reg_rdata,
        .new_sample,
        .sample_left, .sample_right, .sample_valid
    );

    initial clk_100 = 1'b0;
    always #4 clk_100 = ~clk_100;

    // sample strobe, much faster than 48 kHz
    initial begin
        new_sample = 1'b0;
        forever begin
            repeat (SAMPLE_GAP - 1) @(posedge clk_100);
            #1 new_sample = 1'b1;
            @(posedge clk_100);
            #1 new_sample = 1'b0;
        end
    end

    // sample_valid follows new_sample by exactly one cycle
    always @(negedge clk_100) begin
        if (arst_n) begin
            assert (sample_valid === new_sample_q) else begin
                $display("[ERROR] %0t: sample_valid is %b, expected %b",
                         $time, sample_valid, new_sample_q);
                error_count++;
            end
        end
        new_sample_q = new_sample;
    end

    task automatic reg_write(input apu_pkg::reg_addr_t addr, input apu_pkg::reg_data_t data);
        @(posedge clk_100);
        #1;
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge clk_100);
        #1;
        reg_wr    = 1'b0;
    endtask

    task automatic reg_read(input apu_pkg::reg_addr_t addr, output apu_pkg::reg_data_t data);
        @(posedge clk_100);
        #1;
        reg_addr = addr;
        #2;
        data = reg_rdata;  // combinational read path
    endtask

    task automatic check_byte(input string what, input apu_pkg::reg_data_t got,
                              input apu_pkg::reg_data_t exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic flag_sample(input string what, input int idx);
        $display("[ERROR] %0t: %s, sample %0d is L 0x%06h R 0x%06h",
                 $time, what, idx, left_q[idx], right_q[idx]);
        error_count++;
    endtask

    task automatic collect_samples(input int count);
        int waited;
        left_q.delete();
        right_q.delete();
        waited = 0;
        while (left_q.size() < count) begin
            @(negedge clk_100);
            if (sample_valid) begin
                left_q.push_back(sample_left);
                right_q.push_back(sample_right);
                waited = 0;
            end else if (waited == SAMPLE_WAIT) begin
                $display("timeout: no sample_valid pulse within %0d cycles", SAMPLE_WAIT);
                timeout_count++;
                return;
            end else begin
                waited++;
            end
        end
    endtask

    function automatic real duty_fraction(input int code);
        case (code)
            0: return 0.125;
            1: return 0.25;
            2: return 0.5;
            default: return 0.75;
        endcase
    endfunction

    // any nibble of the RAM after a one-bit volume shift
    function automatic bit wave_level_ok(input apu_pkg::sample_t s);
        for (int j = 0; j < 16; j++) begin
            if (s == (apu_pkg::sample_t'(wave_image[j][7:4] >> 1) << 20)) return 1'b1;
            if (s == (apu_pkg::sample_t'(wave_image[j][3:0] >> 1) << 20)) return 1'b1;
        end
        return 1'b0;
    endfunction

    // bit n set when some RAM nibble lands on level n after the shift
    function automatic logic [7:0] wave_levels();
        logic [7:0] lv;
        lv = '0;
        for (int j = 0; j < 16; j++) begin
            lv[wave_image[j][7:4] >> 1] = 1'b1;
            lv[wave_image[j][3:0] >> 1] = 1'b1;
        end
        return lv;
    endfunction

    task automatic test_power_reset();
        apu_pkg::reg_data_t rd;
        reg_read(apu_pkg::ADDR_NR52, rd);
        check_byte("NR52 after reset", rd, 8'h00);
        reg_read(apu_pkg::ADDR_MON, rd);
        check_byte("monitor select after reset", rd, 8'h02);
        collect_samples(4);
        foreach (left_q[i]) begin
            assert (left_q[i] == '0 && right_q[i] == '0) else flag_sample("power off", i);
        end
        reg_write(apu_pkg::ADDR_NR50, 8'h77);
        reg_read(apu_pkg::ADDR_NR50, rd);
        check_byte("NR50 with power off", rd, 8'h00);
        reg_write(apu_pkg::ADDR_NR52, 8'h80);
        reg_write(apu_pkg::ADDR_NR50, 8'h77);
        reg_read(apu_pkg::ADDR_NR50, rd);
        check_byte("NR50 with power on", rd, 8'h77);
        reg_read(apu_pkg::ADDR_NR52, rd);
        check_byte("NR52 after power on", rd, 8'h80);
    endtask

    task automatic test_square_duty();
        int               high;
        real              frac;
        apu_pkg::sample_t hi_level;
        hi_level = apu_pkg::sample_t'(9) << 20;
        reg_write(apu_pkg::ADDR_MON, 8'h00);       // square only
        reg_write(apu_pkg::ADDR_NR12, 8'h90);      // volume 9, envelope held
        reg_write(apu_pkg::ADDR_NR13, 8'hf9);
        for (int duty = 0; duty < 4; duty++) begin
            reg_write(apu_pkg::ADDR_NR11, 8'(duty << 6));
            reg_write(apu_pkg::ADDR_NR14, 8'h87);  // trigger, freq 0x7f9, no length
            collect_samples(2);                    // drop samples from before the trigger
            collect_samples(DUTY_SAMPLES);
            high = 0;
            foreach (left_q[i]) begin
                assert ((left_q[i] == '0 || left_q[i] == hi_level) && right_q[i] == left_q[i])
                else flag_sample("square level", i);
                if (left_q[i] == hi_level) high++;
            end
            frac = real'(high) / real'(DUTY_SAMPLES);
            assert (frac > duty_fraction(duty) - 0.05 && frac < duty_fraction(duty) + 0.05)
            else begin
                $display("[ERROR] %0t: duty code %0d high fraction %0.3f, expected %0.3f",
                         $time, duty, frac, duty_fraction(duty));
                error_count++;
            end
        end
    endtask

    task automatic test_wave_playback();
        logic [7:0] seen;
        for (int i = 0; i < 16; i++) begin
            wave_image[i] = 8'($random(seed));
            reg_write(apu_pkg::ADDR_WAVE_BASE + 6'(i), wave_image[i]);
        end
        reg_write(apu_pkg::ADDR_MON, 8'h01);       // wave only
        reg_write(apu_pkg::ADDR_NR30, 8'h80);
        reg_write(apu_pkg::ADDR_NR32, 8'h40);      // shift code 2
        reg_write(apu_pkg::ADDR_NR33, 8'hf0);
        reg_write(apu_pkg::ADDR_NR34, 8'h87);
        collect_samples(2);
        collect_samples(128);                      // two sweeps, every nibble sampled
        seen = '0;
        foreach (left_q[i]) begin
            assert (wave_level_ok(left_q[i]) && right_q[i] == left_q[i])
            else flag_sample("wave level", i);
            if (wave_level_ok(left_q[i])) seen[left_q[i][22:20]] = 1'b1;
        end
        assert (seen == wave_levels()) else begin
            $display("[ERROR] %0t: wave levels seen 0x%02h, expected 0x%02h",
                     $time, seen, wave_levels());
            error_count++;
        end
    endtask

    task automatic test_length_counter();
        apu_pkg::reg_data_t rd;
        int                 waited;
        // power cycle so both length counters start from zero
        reg_write(apu_pkg::ADDR_NR52, 8'h00);
        reg_write(apu_pkg::ADDR_NR52, 8'h80);
        reg_write(apu_pkg::ADDR_NR30, 8'h80);
        reg_write(apu_pkg::ADDR_NR32, 8'h20);
        reg_write(apu_pkg::ADDR_NR34, 8'h80);      // wave runs without length
        reg_write(apu_pkg::ADDR_NR12, 8'hf0);
        reg_write(apu_pkg::ADDR_NR11, 8'd62);      // two length ticks
        reg_write(apu_pkg::ADDR_NR14, 8'hc7);
        reg_read(apu_pkg::ADDR_NR52, rd);
        check_byte("NR52 after both triggers", rd, 8'h83);
        waited = 0;
        while (rd[0] && waited < LENGTH_WAIT) begin
            reg_read(apu_pkg::ADDR_NR52, rd);
            waited++;
        end
        if (rd[0]) begin
            $display("timeout: square channel still active %0d cycles after its trigger",
                     LENGTH_WAIT);
            timeout_count++;
        end else begin
            check_byte("NR52 after square length end", rd, 8'h82);
            // ticks close frame steps 0 and 2 after power-on
            assert (waited > 2 * apu_pkg::FRAME_DIV && waited <= 3 * apu_pkg::FRAME_DIV)
            else begin
                $display("[ERROR] %0t: square channel stopped after %0d cycles, expected %0d to %0d",
                         $time, waited, 2 * apu_pkg::FRAME_DIV, 3 * apu_pkg::FRAME_DIV);
                error_count++;
            end
        end
    endtask

    task automatic test_pan_volume();
        int               high;
        apu_pkg::sample_t hi_level;
        hi_level = apu_pkg::sample_t'(15 * (3 + 1)) << 13;
        reg_write(apu_pkg::ADDR_MON, 8'h02);
        reg_write(apu_pkg::ADDR_NR50, 8'h30);      // left 3, right 0
        reg_write(apu_pkg::ADDR_NR51, 8'h10);      // square to the left only
        reg_write(apu_pkg::ADDR_NR12, 8'hf0);
        reg_write(apu_pkg::ADDR_NR11, 8'hc0);      // widest duty
        reg_write(apu_pkg::ADDR_NR13, 8'hf9);
        reg_write(apu_pkg::ADDR_NR14, 8'h87);
        collect_samples(2);
        collect_samples(64);
        high = 0;
        foreach (left_q[i]) begin
            assert ((left_q[i] == '0 || left_q[i] == hi_level) && right_q[i] == '0)
            else flag_sample("panned mix", i);
            if (left_q[i] == hi_level) high++;
        end
        assert (high > 0) else begin
            $display("[ERROR] %0t: left side never reached the square level", $time);
            error_count++;
        end
    endtask

    task automatic test_ramp();
        int               start;
        apu_pkg::sample_t exp;
        reg_write(apu_pkg::ADDR_MON, 8'h03);
        collect_samples(2);
        collect_samples(80);                       // long enough to wrap once
        start = 0;
        if (left_q.size() > 0) start = int'(left_q[0] >> 18);
        for (int i = 0; i < left_q.size(); i++) begin
            exp = apu_pkg::sample_t'((start + i) % 64) << 18;
            assert (left_q[i] == exp && right_q[i] == exp) else flag_sample("ramp step", i);
        end
    endtask

    initial begin
        seed          = 61430;
        error_count   = 0;
        timeout_count = 0;
        new_sample_q  = 1'b0;
        arst_n        = 1'b0;
        reg_wr        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        repeat (5) @(posedge clk_100);
        #1 arst_n = 1'b1;

        test_power_reset();
        test_square_duty();
        test_wave_playback();
        test_length_counter();
        test_pan_volume();
        test_ramp();

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

// File: project.f
source/apu_pkg.sv
source/chan_regs_if.sv
source/frame_sequencer.sv
source/apu_regs.sv
source/square_channel.sv
source/wave_channel.sv
source/sound_mixer.sv
source/apu_top.sv
verification/tb_apu_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_apu_top
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
